//--- verilog/id_params.svh
// RV32 decode stage parameters.
// Fixed widths, register count, trap cause codes and the
// privileged instruction encodings shared by the decode blocks.

`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Data path width.
`define XLEN 32

// Register index width and number of architectural registers.
`define REG_AW 5
`define REG_COUNT 32

// Trap cause field width.
`define CAUSE_W 4

// Illegal instruction exception cause.
`define CAUSE_ILLEGAL 4'd2

// Upper 12 bits of the MRET encoding (funct7 and rs2 fields).
`define INSN_MRET 12'h302

// Upper 12 bits of the WFI encoding.
`define INSN_WFI 12'h105

`endif

//--- verilog/id_pkg.sv
// Decode stage types.
// Opcode and funct3 enums plus the packets exchanged with
// fetch, execute and write-back.

`include "id_params.svh"

package id_pkg;

    // Major opcodes in instruction bits 6 to 2.
    typedef enum logic [4:0] {
        RV_OP_LOAD     = 5'b00000,
        RV_OP_MISC_MEM = 5'b00011,
        RV_OP_OP_IMM   = 5'b00100,
        RV_OP_AUIPC    = 5'b00101,
        RV_OP_STORE    = 5'b01000,
        RV_OP_OP       = 5'b01100,
        RV_OP_LUI      = 5'b01101,
        RV_OP_BRANCH   = 5'b11000,
        RV_OP_JALR     = 5'b11001,
        RV_OP_JAL      = 5'b11011,
        RV_OP_SYSTEM   = 5'b11100
    } rv_opcode_e;

    // ALU funct3 codes.
    typedef enum logic [2:0] {
        RV_ALU_ADD  = 3'b000,
        RV_ALU_SLL  = 3'b001,
        RV_ALU_SLT  = 3'b010,
        RV_ALU_SLTU = 3'b011,
        RV_ALU_XOR  = 3'b100,
        RV_ALU_SRL  = 3'b101,
        RV_ALU_OR   = 3'b110,
        RV_ALU_AND  = 3'b111
    } rv_funct3_e;

    // IF/ID packet.
    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:1]    pc;      // Halfword aligned.
        logic [31:0]         insn;
        logic                trap;
        logic [`CAUSE_W-1:0] cause;
    } fetch_pkt_t;

    // ID/EX packet.
    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:1]    pc;
        logic [31:0]         insn;
        logic                use_rd;
        logic [`XLEN-1:0]    rs1_val;
        logic [`XLEN-1:0]    rs2_val;
        logic                branch;
        logic                branch_predict;
        logic                trap;
        logic [`CAUSE_W-1:0] cause;
    } ex_pkt_t;

    // Register write-back request.
    typedef struct packed {
        logic                we;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    wdata;
    } wb_req_t;

    // Control flow decoded for fetch.
    typedef struct packed {
        logic                is_xret;
        logic                is_jump;
        logic                is_branch;
        logic                branch_predict;
        logic                bt_use_rs1;
        logic [`XLEN-1:1]    target;
    } redirect_t;

endpackage

//--- verilog/id_regfile.sv
// Write-first integer register file.
// Registers 1 to 31 with two combinational read ports and one
// write port; x0 reads as zero and a same-cycle write is bypassed.

`timescale 1ns/1ps

`include "id_params.svh"

module id_regfile
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  wb_req_t            wb,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2
);

    // No storage for x0.
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    // One read port with write-first bypass.
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] idx);
        logic [`XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.we && wb.rd == idx) begin
            val = wb.wdata;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign rdata1 = read_port(rs1);
    assign rdata2 = read_port(rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Whole file starts out zeroed.
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

endmodule

//--- verilog/id_insn_check.sv
// Instruction validity check for RV32IM with Zicsr.
// Flags unknown or malformed encodings; the core runs in machine
// mode only, so every valid encoding is also legal.

`timescale 1ns/1ps

`include "id_params.svh"

module id_insn_check
    import id_pkg::*;
(
    input  logic [31:0] insn,
    output logic        valid,
    output logic        legal
);

    rv_opcode_e opcode;
    rv_funct3_e alu_op;
    logic       valid_op_imm;
    logic       valid_op;
    logic       valid_system;

    assign opcode = rv_opcode_e'(insn[6:2]);
    assign alu_op = rv_funct3_e'(insn[14:12]);

    // Shift immediates need a clean funct7.
    always_comb begin
        case (alu_op)
            RV_ALU_SLL: valid_op_imm = insn[31:25] == 7'b0;
            // SRAI sets bit 30.
            RV_ALU_SRL: valid_op_imm = !insn[31] && insn[29:25] == 5'b0;
            default:    valid_op_imm = 1'b1;
        endcase
    end

    // Register-register ALU ops.
    always_comb begin
        if (insn[31:25] == 7'b0000001) begin
            // M extension defines every funct3 value.
            valid_op = 1'b1;
        end else begin
            case (alu_op)
                RV_ALU_ADD: valid_op = !insn[31] && insn[29:25] == 5'b0;
                RV_ALU_SRL: valid_op = !insn[31] && insn[29:25] == 5'b0;
                default:    valid_op = insn[31:25] == 7'b0;
            endcase
        end
    end

    // SYSTEM holds privileged ops and CSR access.
    always_comb begin
        if (insn[14:12] == 3'b000) begin
            casez (insn[31:20])
                12'b0000000_0000?: valid_system = 1'b1;  // ECALL, EBREAK.
                `INSN_MRET:        valid_system = 1'b1;
                `INSN_WFI:         valid_system = 1'b1;
                default:           valid_system = 1'b0;
            endcase
        end else begin
            valid_system = insn[14:12] != 3'b100;
        end
    end

    always_comb begin
        if (insn[1:0] != 2'b11) begin
            // Compressed encodings are not supported.
            valid = 1'b0;
        end else begin
            case (opcode)
                RV_OP_LOAD: begin
                    valid = insn[14] ? insn[13:12] < 2'd2 : insn[13:12] < 2'd3;
                end
                RV_OP_MISC_MEM: valid = insn[14:13] == 2'b00;
                RV_OP_OP_IMM:   valid = valid_op_imm;
                RV_OP_AUIPC:    valid = 1'b1;
                RV_OP_STORE:    valid = !insn[14] && insn[13:12] < 2'd3;
                RV_OP_OP:       valid = valid_op;
                RV_OP_LUI:      valid = 1'b1;
                // Only funct3 2 and 3 are unused.
                RV_OP_BRANCH:   valid = insn[14] || !insn[13];
                RV_OP_JALR:     valid = insn[14:12] == 3'b000;
                RV_OP_JAL:      valid = 1'b1;
                RV_OP_SYSTEM:   valid = valid_system;
                default:        valid = 1'b0;
            endcase
        end
    end

    // Machine mode only.
    assign legal = 1'b1;

endmodule

//--- verilog/id_rd_decode.sv
// Destination register decoder.
// Tells whether an instruction writes back to RD.

`timescale 1ns/1ps

module id_rd_decode
    import id_pkg::*;
(
    input  logic [31:0] insn,
    output logic        use_rd
);

    rv_opcode_e opcode;

    assign opcode = rv_opcode_e'(insn[6:2]);

    always_comb begin
        case (opcode)
            RV_OP_LOAD: begin
                use_rd = 1'b1;
            end
            RV_OP_OP_IMM,
            RV_OP_OP: begin
                use_rd = 1'b1;
            end
            RV_OP_AUIPC,
            RV_OP_LUI: begin
                use_rd = 1'b1;
            end
            // Link register.
            RV_OP_JAL,
            RV_OP_JALR: begin
                use_rd = 1'b1;
            end
            RV_OP_SYSTEM: begin
                // CSR ops return the old value; ECALL and friends don't.
                use_rd = insn[14:12] != 3'b000;
            end
            RV_OP_STORE,
            RV_OP_BRANCH,
            RV_OP_MISC_MEM: begin
                use_rd = 1'b0;
            end
            default: begin
                use_rd = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/id_branch_decode.sv
// Control flow decoder.
// Classifies JAL, JALR, conditional branches and MRET, and computes
// the target through a single shared adder. Static prediction takes
// backward branches.

`timescale 1ns/1ps

`include "id_params.svh"

module id_branch_decode
    import id_pkg::*;
(
    input  logic [31:0]      insn,
    input  logic [`XLEN-1:1] pc,
    input  logic [`XLEN-1:0] rs1_val,
    output redirect_t        redir
);

    rv_opcode_e       opcode;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] add_lhs;
    logic [`XLEN-1:0] add_rhs;
    logic [`XLEN-1:0] add_res;

    assign opcode = rv_opcode_e'(insn[6:2]);

    // Sign-extended immediates.
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

    // Operand select.
    always_comb begin
        redir.is_jump    = 1'b0;
        redir.is_branch  = 1'b0;
        redir.bt_use_rs1 = 1'b0;
        add_lhs          = {pc, 1'b0};
        add_rhs          = imm_b;
        case (opcode)
            RV_OP_JAL: begin
                redir.is_jump = 1'b1;
                add_rhs       = imm_j;
            end
            RV_OP_JALR: begin
                redir.is_jump    = 1'b1;
                redir.bt_use_rs1 = 1'b1;
                add_lhs          = rs1_val;
                add_rhs          = imm_i;
            end
            RV_OP_BRANCH: begin
                redir.is_branch = 1'b1;
            end
            default: begin
                // Target unused here.
                add_rhs = imm_b;
            end
        endcase
    end

    assign add_res = add_lhs + add_rhs;

    // Bit 0 is dropped, as JALR requires.
    assign redir.target = add_res[`XLEN-1:1];

    // Negative offset means a backward branch.
    assign redir.branch_predict = insn[31];

    assign redir.is_xret = opcode == RV_OP_SYSTEM
                        && insn[14:12] == 3'b000
                        && insn[31:20] == `INSN_MRET;

endmodule

//--- verilog/id_stage.sv
// RV32 instruction decode stage.
// Reads operands, validates and decodes the fetched instruction,
// reports control flow to fetch and registers the result into the
// ID/EX barrier under control of the hazard unit.

`timescale 1ns/1ps

`include "id_params.svh"

module id_stage
    import id_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkt_t       d,
    input  wb_req_t          wb,
    input  logic             stall_id,
    input  logic             stall_ex,
    input  logic             fw_rs1,
    input  logic             fw_rs2,
    input  logic [`XLEN-1:0] fw_val,
    output ex_pkt_t          q,
    output redirect_t        redir
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             insn_valid;
    logic             insn_legal;
    logic             insn_ok;
    logic             use_rd;

    id_regfile i_regfile (
        .clk    (clk),
        .rst    (rst),
        .wb     (wb),
        .rs1    (d.insn[19:15]),
        .rs2    (d.insn[24:20]),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    id_insn_check i_insn_check (
        .insn  (d.insn),
        .valid (insn_valid),
        .legal (insn_legal)
    );

    id_rd_decode i_rd_decode (
        .insn   (d.insn),
        .use_rd (use_rd)
    );

    // Redirect goes straight to fetch.
    id_branch_decode i_branch_decode (
        .insn    (d.insn),
        .pc      (d.pc),
        .rs1_val (rs1_val),
        .redir   (redir)
    );

    assign insn_ok = insn_valid && insn_legal;

    // Barrier control bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            q.valid <= 1'b0;
            q.trap  <= 1'b0;
        end else if (!stall_id) begin
            q.valid <= d.valid && insn_ok;
            q.trap  <= d.trap || (d.valid && !insn_ok);
        end else begin
            // Bubble unless execute is held too.
            q.valid <= q.valid && stall_ex;
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        if (!stall_id) begin
            q.pc             <= d.pc;
            q.insn           <= d.insn;
            q.use_rd         <= use_rd;
            q.rs1_val        <= fw_rs1 ? fw_val : rs1_val;
            q.rs2_val        <= fw_rs2 ? fw_val : rs2_val;
            q.branch         <= redir.is_branch;
            q.branch_predict <= redir.branch_predict;
            q.cause          <= d.trap ? d.cause : `CAUSE_ILLEGAL;
        end
    end

endmodule

//--- sim/id_tb_tasks.svh
// Decode stage testbench helpers.
// Instruction encoders, the LFSR stimulus source, the compare task
// and the clock stepping and wait tasks used by the directed tests.

`ifndef ID_TB_TASKS_SVH
`define ID_TB_TASKS_SVH

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_state = 32'h44a6_57cc;
logic [31:0] exp_regs [0:31];
int          err_count = 0;

// Galois LFSR stepped once per bit taken.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        val = {val[30:0], b};
    end
    return val;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] op);
    return {f7, rs2, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] op);
    return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], RV_OP_STORE, 2'b11};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], RV_OP_BRANCH, 2'b11};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, RV_OP_JAL, 2'b11};
endfunction

task automatic check_val(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
        err_count++;
        $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

// Advance to 2 ns after the next rising edge.
task automatic step();
    @(posedge clk);
    #2;
endtask

task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    while (rst) begin
        step();
        cycles++;
        if (cycles > 50) begin
            $display("Reset was never released");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end
endtask

// Present one valid instruction and move to the cycle where q holds it.
task automatic issue(input logic [31:0] insn, input logic [31:1] pc);
    d.valid = 1'b1;
    d.trap  = 1'b0;
    d.cause = '0;
    d.insn  = insn;
    d.pc    = pc;
    step();
endtask

`endif

//--- sim/id_stage_tb.sv
// Decode stage testbench.
// Directed tests for the register file, forwarding, validation,
// redirect decode and the stall and bubble behavior of the barrier.

`timescale 1ns/1ps

`include "id_params.svh"

module id_stage_tb
    import id_pkg::*;
;
    logic             clk;
    logic             rst;
    fetch_pkt_t       d;
    wb_req_t          wb;
    logic             stall_id;
    logic             stall_ex;
    logic             fw_rs1;
    logic             fw_rs2;
    logic [`XLEN-1:0] fw_val;
    ex_pkt_t          q;
    redirect_t        redir;

    `include "id_tb_tasks.svh"

    id_stage i_id_stage (
        .clk      (clk),
        .rst      (rst),
        .d        (d),
        .wb       (wb),
        .stall_id (stall_id),
        .stall_ex (stall_ex),
        .fw_rs1   (fw_rs1),
        .fw_rs2   (fw_rs2),
        .fw_val   (fw_val),
        .q        (q),
        .redir    (redir)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #2000000;
        $display("Simulation timed out");
        $display("TESTS FAILED");
        $fatal(1);
    end

    task automatic test_regfile();
        logic [31:0] v;
        for (int r = 1; r < 8; r++) begin
            exp_regs[r] = rand_bits(32);
            wb.we = 1'b1;
            wb.rd = 5'(r);
            wb.wdata = exp_regs[r];
            step();
        end
        // Write to x0 must be ignored.
        wb.rd = 5'd0;
        wb.wdata = rand_bits(32);
        step();
        wb.we = 1'b0;
        for (int r = 1; r < 7; r++) begin
            issue(enc_r(7'd0, 5'(r + 1), 5'(r), 3'd0, 5'd9, RV_OP_OP), 31'(r * 2));
            check_val("q.rs1_val", q.rs1_val, exp_regs[r]);
            check_val("q.rs2_val", q.rs2_val, exp_regs[r + 1]);
        end
        issue(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd9, RV_OP_OP), 31'd4);
        check_val("q.rs1_val x0", q.rs1_val, 32'd0);
        // Write-first bypass.
        v = rand_bits(32);
        wb.we = 1'b1;
        wb.rd = 5'd7;
        wb.wdata = v;
        exp_regs[7] = v;
        issue(enc_r(7'd0, 5'd7, 5'd7, 3'd0, 5'd9, RV_OP_OP), 31'd8);
        wb.we = 1'b0;
        check_val("q.rs1_val bypass", q.rs1_val, v);
        check_val("q.rs2_val bypass", q.rs2_val, v);
    endtask

    task automatic test_forwarding();
        fw_val = rand_bits(32);
        fw_rs1 = 1'b1;
        issue(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd9, RV_OP_OP), 31'd12);
        check_val("q.rs1_val fw", q.rs1_val, fw_val);
        check_val("q.rs2_val", q.rs2_val, exp_regs[2]);
        fw_rs1 = 1'b0;
        fw_rs2 = 1'b1;
        issue(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd9, RV_OP_OP), 31'd16);
        check_val("q.rs1_val", q.rs1_val, exp_regs[1]);
        check_val("q.rs2_val fw", q.rs2_val, fw_val);
        fw_rs2 = 1'b0;
    endtask

    task automatic check_valid_insn(input logic [31:0] insn, input logic exp_use_rd,
                                    input logic exp_branch);
        logic [31:1] pc;
        pc = 31'(rand_bits(31));
        issue(insn, pc);
        check_val("q.pc", 32'(q.pc), 32'(pc));
        check_val("q.insn", q.insn, insn);
        check_val("q.use_rd", 32'(q.use_rd), 32'(exp_use_rd));
        check_val("q.branch", 32'(q.branch), 32'(exp_branch));
        check_val("q.branch_predict", 32'(q.branch_predict), 32'(insn[31]));
        check_val("q.valid", 32'(q.valid), 32'd1);
        check_val("q.trap", 32'(q.trap), 32'd0);
    endtask

    task automatic check_illegal_insn(input logic [31:0] insn);
        issue(insn, 31'd20);
        check_val("q.valid", 32'(q.valid), 32'd0);
        check_val("q.trap", 32'(q.trap), 32'd1);
        check_val("q.cause", 32'(q.cause), 32'(`CAUSE_ILLEGAL));
    endtask

    task automatic test_validation();
        check_valid_insn({20'(rand_bits(20)), 5'd3, RV_OP_LUI, 2'b11}, 1'b1, 1'b0);
        check_valid_insn(enc_i(12'(rand_bits(12)), 5'd1, 3'd0, 5'd2, RV_OP_OP_IMM), 1'b1, 1'b0);
        check_valid_insn(enc_r(7'd1, 5'd2, 5'd1, 3'd0, 5'd4, RV_OP_OP), 1'b1, 1'b0);
        check_valid_insn(enc_s(12'(rand_bits(12)), 5'd2, 5'd1, 3'd2), 1'b0, 1'b0);
        // Backward branch.
        check_valid_insn(enc_b(13'h1ff0, 5'd2, 5'd1, 3'd0), 1'b0, 1'b1);
        check_valid_insn(enc_i(12'h300, 5'd1, 3'd1, 5'd5, RV_OP_SYSTEM), 1'b1, 1'b0);
        check_valid_insn(enc_i(`INSN_MRET, 5'd0, 3'd0, 5'd0, RV_OP_SYSTEM), 1'b0, 1'b0);
        check_valid_insn(enc_i(12'h000, 5'd0, 3'd0, 5'd0, RV_OP_SYSTEM), 1'b0, 1'b0);
        check_illegal_insn(enc_i(12'h300, 5'd1, 3'd4, 5'd5, RV_OP_SYSTEM));
        check_illegal_insn(enc_i(12'h004, 5'd1, 3'd1, 5'd1, RV_OP_JALR));
        check_illegal_insn(32'h0000_4501);
        check_illegal_insn(32'h0000_007f);
        // Fetch trap keeps its own cause.
        d.valid = 1'b0;
        d.trap  = 1'b1;
        d.cause = 4'd5;
        step();
        check_val("q.valid", 32'(q.valid), 32'd0);
        check_val("q.trap", 32'(q.trap), 32'd1);
        check_val("q.cause", 32'(q.cause), 32'd5);
        d.trap = 1'b0;
    endtask

    task automatic check_redirect(input logic [31:0] exp_target, input logic jump,
                                  input logic branch, input logic use_rs1,
                                  input logic xret);
        #1;
        check_val("redir.target", {1'b0, redir.target}, exp_target >> 1);
        check_val("redir.is_jump", 32'(redir.is_jump), 32'(jump));
        check_val("redir.is_branch", 32'(redir.is_branch), 32'(branch));
        check_val("redir.bt_use_rs1", 32'(redir.bt_use_rs1), 32'(use_rs1));
        check_val("redir.branch_predict", 32'(redir.branch_predict), 32'(d.insn[31]));
        check_val("redir.is_xret", 32'(redir.is_xret), 32'(xret));
        step();
    endtask

    task automatic test_redirect();
        logic [20:0] imm_j;
        logic [11:0] imm_i;
        logic [12:0] imm_b;
        logic [31:0] pc_full;
        for (int n = 0; n < 4; n++) begin
            pc_full = {31'(rand_bits(31)), 1'b0};
            d.valid = 1'b1;
            d.pc = pc_full[31:1];
            imm_j = {20'(rand_bits(20)), 1'b0};
            d.insn = enc_j(imm_j, 5'd1);
            check_redirect(pc_full + {{11{imm_j[20]}}, imm_j}, 1'b1, 1'b0, 1'b0, 1'b0);
            imm_i = 12'(rand_bits(12));
            d.insn = enc_i(imm_i, 5'd3, 3'd0, 5'd1, RV_OP_JALR);
            check_redirect(exp_regs[3] + {{20{imm_i[11]}}, imm_i}, 1'b1, 1'b0, 1'b1, 1'b0);
            imm_b = {12'(rand_bits(12)), 1'b0};
            d.insn = enc_b(imm_b, 5'd2, 5'd1, 3'd0);
            check_redirect(pc_full + {{19{imm_b[12]}}, imm_b}, 1'b0, 1'b1, 1'b0, 1'b0);
        end
        d.insn = enc_i(`INSN_MRET, 5'd0, 3'd0, 5'd0, RV_OP_SYSTEM);
        #1;
        check_val("redir.is_xret", 32'(redir.is_xret), 32'd1);
        step();
    endtask

    task automatic test_stall();
        logic [31:0] insn_a;
        logic [31:0] insn_b;
        insn_a = enc_i(12'h011, 5'd1, 3'd0, 5'd2, RV_OP_OP_IMM);
        insn_b = enc_i(12'h022, 5'd1, 3'd0, 5'd3, RV_OP_OP_IMM);
        issue(insn_a, 31'd40);
        stall_id = 1'b1;
        stall_ex = 1'b1;
        issue(insn_b, 31'd42);
        check_val("q.insn held", q.insn, insn_a);
        check_val("q.valid held", 32'(q.valid), 32'd1);
        stall_ex = 1'b0;
        step();
        check_val("q.insn held", q.insn, insn_a);
        check_val("q.valid bubble", 32'(q.valid), 32'd0);
        stall_id = 1'b0;
        step();
        check_val("q.insn released", q.insn, insn_b);
        check_val("q.valid released", 32'(q.valid), 32'd1);
    endtask

    initial begin
        rst = 1'b1;
        d = '0;
        // Reset has to win over a valid, trapping packet.
        d.valid = 1'b1;
        d.trap = 1'b1;
        d.insn = enc_i(12'h000, 5'd0, 3'd0, 5'd0, RV_OP_OP_IMM);
        wb = '0;
        stall_id = 1'b0;
        stall_ex = 1'b0;
        fw_rs1 = 1'b0;
        fw_rs2 = 1'b0;
        fw_val = '0;
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        wait_reset_done();
        check_val("q.valid after reset", 32'(q.valid), 32'd0);
        check_val("q.trap after reset", 32'(q.trap), 32'd0);
        d = '0;
        test_regfile();
        test_forwarding();
        test_validation();
        test_redirect();
        test_stall();
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
+incdir+sim
verilog/id_pkg.sv
verilog/id_regfile.sv
verilog/id_insn_check.sv
verilog/id_rd_decode.sv
verilog/id_branch_decode.sv
verilog/id_stage.sv
sim/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

( verilator --binary --timing -f project.f --top-module id_stage_tb \
    && ./obj_dir/Vid_stage_tb ) > sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
    || grep -q "TESTS PASSED" sim.log && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation did not complete, see sim.log"; exit 1; }
